/* ppu_timing_pkg.sv */
// PPU line and frame timing constants with the STAT mode encoding
package ppu_timing_pkg;

	// ------------------------------
	// line geometry
	// ------------------------------

	// one scan line in cpu clocks
	localparam int LINE_CYCLES = 456;
	// oam search length at the start of each line
	localparam int OAM_CYCLES = 80;
	// visible pixels per line
	localparam int SCREEN_W = 160;

	// ------------------------------
	// frame geometry
	// ------------------------------

	// visible lines plus vblank lines
	localparam int FRAME_LINES = 154;
	localparam int VISIBLE_LINES = 144;

	// mode code as seen in STAT[1:0]
	typedef enum logic [1:0] {
		HBLANK = 2'd0,
		VBLANK = 2'd1,
		OAM    = 2'd2,
		DRAW   = 2'd3
	} ppu_mode_e;

endpackage

/* ppu_reg_pkg.sv */
// PPU register map with reset values, LCDC and STAT bit fields and the register struct
package ppu_reg_pkg;

	// ------------------------------
	// register offsets
	// ------------------------------

	localparam logic [7:0] REG_LCDC = 8'h40;
	localparam logic [7:0] REG_STAT = 8'h41;
	localparam logic [7:0] REG_SCY  = 8'h42;
	localparam logic [7:0] REG_SCX  = 8'h43;
	// read only, current line
	localparam logic [7:0] REG_LY   = 8'h44;
	localparam logic [7:0] REG_LYC  = 8'h45;
	// a write here also starts the oam dma
	localparam logic [7:0] REG_DMA  = 8'h46;
	localparam logic [7:0] REG_BGP  = 8'h47;
	localparam logic [7:0] REG_OBP0 = 8'h48;
	localparam logic [7:0] REG_OBP1 = 8'h49;
	localparam logic [7:0] REG_WY   = 8'h4A;
	localparam logic [7:0] REG_WX   = 8'h4B;

	// size of the sprite attribute memory
	localparam int OAM_BYTES = 160;

	// LCDC bits in use
	localparam int LCDC_ON       = 7;
	localparam int LCDC_TILE_SEL = 4;
	localparam int LCDC_MAP_SEL  = 3;
	localparam int LCDC_BG_ENA   = 0;

	// STAT interrupt enables
	localparam int STAT_LYC_IE = 6;
	localparam int STAT_OAM_IE = 5;
	localparam int STAT_VBL_IE = 4;
	localparam int STAT_HBL_IE = 3;

	// writable registers in one bundle
	typedef struct packed {
		logic [7:0] lcdc;
		logic [7:0] stat;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] lyc;
		logic [7:0] dma;
		logic [7:0] bgp;
		logic [7:0] obp0;
		logic [7:0] obp1;
		logic [7:0] wy;
		logic [7:0] wx;
	} ppu_regs_t;

	// lcd starts switched off
	localparam ppu_regs_t REGS_RESET = '{
		lcdc: 8'h00, stat: 8'h00, scy: 8'h00, scx: 8'h00,
		lyc: 8'h00, dma: 8'h00, bgp: 8'hFC, obp0: 8'hFF,
		obp1: 8'hFF, wy: 8'h00, wx: 8'h00
	};

endpackage

/* ppu_ifs.sv */
// OAM access port and line timing bundles shared between the PPU blocks
`timescale 1ns/1ps

// ------------------------------
// one requester into the oam memory
// ------------------------------
interface oam_port_if;
	logic       req;
	logic       we;
	logic [7:0] addr;
	logic [7:0] wdata;
	// combinational answer in the same cycle
	logic [7:0] rdata;

	modport requester (output req, we, addr, wdata, input rdata);
	modport memory (input req, we, addr, wdata, output rdata);
endinterface

// ------------------------------
// line position from the timer
// ------------------------------
interface line_timing_if;
	logic [8:0] h_cnt;
	logic [7:0] v_cnt;
	// mode 3 of a visible line
	logic       draw;
	// last cycle of the line
	logic       line_end;
	// scroll values frozen for the line
	logic [7:0] scx_l;
	logic [7:0] scy_l;

	modport timer (output h_cnt, v_cnt, draw, line_end, scx_l, scy_l);
	modport fetcher (input h_cnt, v_cnt, draw, line_end, scx_l, scy_l);
endinterface

/* ppu_regs.sv */
// PPU CPU register file with write decode, readback mux and LYC compare
`timescale 1ns/1ps

module ppu_regs (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cpu_sel_reg,
	input  logic                      cpu_sel_oam,
	input  logic [7:0]                cpu_addr,
	input  logic                      cpu_wr,
	input  logic [7:0]                cpu_di,
	input  logic [7:0]                oam_rdata,
	input  logic [7:0]                ly,
	input  ppu_timing_pkg::ppu_mode_e mode,
	output logic [7:0]                cpu_do,
	output ppu_reg_pkg::ppu_regs_t    regs,
	output logic                      dma_start
);

	logic wr_en;
	logic lyc_match;

	assign wr_en = cpu_sel_reg && cpu_wr;
	// coincidence flag shown in STAT bit 2
	assign lyc_match = (ly == regs.lyc);
	// dma engine starts on the same edge as the register write
	assign dma_start = wr_en && (cpu_addr == ppu_reg_pkg::REG_DMA);

	// ------------------------------
	// register writes
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= ppu_reg_pkg::REGS_RESET;
		end else if (wr_en) begin
			case (cpu_addr)
				ppu_reg_pkg::REG_LCDC: regs.lcdc <= cpu_di;
				ppu_reg_pkg::REG_STAT: regs.stat <= cpu_di;
				ppu_reg_pkg::REG_SCY:  regs.scy  <= cpu_di;
				ppu_reg_pkg::REG_SCX:  regs.scx  <= cpu_di;
				ppu_reg_pkg::REG_LYC:  regs.lyc  <= cpu_di;
				ppu_reg_pkg::REG_DMA:  regs.dma  <= cpu_di;
				ppu_reg_pkg::REG_BGP:  regs.bgp  <= cpu_di;
				ppu_reg_pkg::REG_OBP0: regs.obp0 <= cpu_di;
				ppu_reg_pkg::REG_OBP1: regs.obp1 <= cpu_di;
				ppu_reg_pkg::REG_WY:   regs.wy   <= cpu_di;
				ppu_reg_pkg::REG_WX:   regs.wx   <= cpu_di;
				// LY is read only
				default: regs <= regs;
			endcase
		end
	end

	// ------------------------------
	// readback
	// ------------------------------
	always_comb begin
		if (cpu_sel_oam) begin
			cpu_do = oam_rdata;
		end else begin
			case (cpu_addr)
				ppu_reg_pkg::REG_LCDC: cpu_do = regs.lcdc;
				// bit 7 always reads as one
				ppu_reg_pkg::REG_STAT: cpu_do = {1'b1,
					regs.stat[ppu_reg_pkg::STAT_LYC_IE:ppu_reg_pkg::STAT_HBL_IE],
					lyc_match, mode};
				ppu_reg_pkg::REG_SCY:  cpu_do = regs.scy;
				ppu_reg_pkg::REG_SCX:  cpu_do = regs.scx;
				ppu_reg_pkg::REG_LY:   cpu_do = ly;
				ppu_reg_pkg::REG_LYC:  cpu_do = regs.lyc;
				ppu_reg_pkg::REG_DMA:  cpu_do = regs.dma;
				ppu_reg_pkg::REG_BGP:  cpu_do = regs.bgp;
				ppu_reg_pkg::REG_OBP0: cpu_do = regs.obp0;
				ppu_reg_pkg::REG_OBP1: cpu_do = regs.obp1;
				ppu_reg_pkg::REG_WY:   cpu_do = regs.wy;
				ppu_reg_pkg::REG_WX:   cpu_do = regs.wx;
				// open bus
				default: cpu_do = 8'hFF;
			endcase
		end
	end

	// the two cpu selects decode disjoint address ranges
	a_sel_excl: assert property (@(posedge clk) disable iff (reset)
		!(cpu_sel_reg && cpu_sel_oam));

endmodule

/* ppu_line_timer.sv */
// PPU line and frame timer with scroll latching, STAT mode decode and STAT interrupt
`timescale 1ns/1ps

module ppu_line_timer #(
	parameter int FRAME_LINES   = ppu_timing_pkg::FRAME_LINES,
	parameter int VISIBLE_LINES = ppu_timing_pkg::VISIBLE_LINES
) (
	input  logic                      clk,
	input  logic                      reset,
	input  ppu_reg_pkg::ppu_regs_t    regs,
	line_timing_if.timer              lt,
	output ppu_timing_pkg::ppu_mode_e mode,
	output logic                      irq
);

	localparam logic [8:0] H_LAST  = 9'(ppu_timing_pkg::LINE_CYCLES - 1);
	localparam logic [8:0] H_OAM   = 9'(ppu_timing_pkg::OAM_CYCLES);
	// latch two clocks before the first fetch slot
	localparam logic [8:0] H_LATCH = 9'(ppu_timing_pkg::OAM_CYCLES - 2);
	localparam logic [8:0] H_DRAW  = 9'(ppu_timing_pkg::OAM_CYCLES + ppu_timing_pkg::SCREEN_W);
	localparam logic [7:0] V_LAST  = 8'(FRAME_LINES - 1);
	localparam logic [7:0] V_VIS   = 8'(VISIBLE_LINES);

	logic       lcd_on;
	logic [8:0] h_cnt;
	logic [7:0] v_cnt;
	logic [7:0] scx_l;
	logic [7:0] scy_l;
	logic [8:0] draw_end;

	assign lcd_on = regs.lcdc[ppu_reg_pkg::LCDC_ON];
	// fine x scroll costs one extra tile fetch
	assign draw_end = H_DRAW + {5'd0, |scx_l[2:0], 3'd0};

	// ------------------------------
	// counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || !lcd_on) begin
			// frozen at the top left while the lcd is off
			h_cnt <= 9'd0;
			v_cnt <= 8'd0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= 9'd0;
			v_cnt <= (v_cnt == V_LAST) ? 8'd0 : v_cnt + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// scroll stays stable for the whole line
	always_ff @(posedge clk) begin
		if (h_cnt == H_LATCH) begin
			scx_l <= regs.scx;
			scy_l <= regs.scy;
		end
	end

	// mode decode
	always_comb begin
		if (!lcd_on)
			mode = ppu_timing_pkg::HBLANK;
		else if (v_cnt >= V_VIS)
			mode = ppu_timing_pkg::VBLANK;
		else if (h_cnt < H_OAM)
			mode = ppu_timing_pkg::OAM;
		else if (h_cnt < draw_end)
			mode = ppu_timing_pkg::DRAW;
		else
			mode = ppu_timing_pkg::HBLANK;
	end

	assign lt.h_cnt    = h_cnt;
	assign lt.v_cnt    = v_cnt;
	assign lt.draw     = (mode == ppu_timing_pkg::DRAW);
	assign lt.line_end = (h_cnt == H_LAST);
	assign lt.scx_l    = scx_l;
	assign lt.scy_l    = scy_l;

	// ------------------------------
	// STAT interrupt
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			irq <= 1'b0;
		end else begin
			// any enabled source gives a single cycle pulse
			irq <= lcd_on && (
				(regs.stat[ppu_reg_pkg::STAT_LYC_IE] && (h_cnt == 9'd1) &&
					(v_cnt == regs.lyc)) ||
				(regs.stat[ppu_reg_pkg::STAT_OAM_IE] && (h_cnt == 9'd0)) ||
				(regs.stat[ppu_reg_pkg::STAT_VBL_IE] && (h_cnt == H_LAST) &&
					(v_cnt == V_VIS - 8'd1)) ||
				(regs.stat[ppu_reg_pkg::STAT_HBL_IE] && (h_cnt == draw_end)));
		end
	end

	a_h_range: assert property (@(posedge clk) disable iff (reset) h_cnt <= H_LAST);

endmodule

/* ppu_bg_fetcher.sv */
// PPU background fetcher that reads VRAM, shifts tile pixels and maps them through BGP
`timescale 1ns/1ps

module ppu_bg_fetcher (
	input  logic                   clk,
	input  logic                   reset,
	input  ppu_reg_pkg::ppu_regs_t regs,
	line_timing_if.fetcher         lt,
	output logic                   vram_rd,
	output logic [12:0]            vram_addr,
	input  logic [7:0]             vram_data,
	output logic                   lcd_clkena,
	output logic [1:0]             lcd_data
);

	// line setup one clock before the first map slot
	localparam logic [8:0] H_INIT   = 9'(ppu_timing_pkg::OAM_CYCLES - 1);
	localparam logic [7:0] PIX_LAST = 8'(ppu_timing_pkg::SCREEN_W);

	logic [1:0] slot;
	logic       sample;
	logic       load;
	logic [7:0] bg_line;
	logic       tile_a12;
	logic [4:0] col;
	logic [7:0] tile;
	logic [7:0] data0;
	logic [7:0] data1;
	logic [7:0] shift0;
	logic [7:0] shift1;
	logic       active;
	logic [2:0] skip;
	logic [7:0] pcnt;
	logic [1:0] cidx;

	// ------------------------------
	// fetch slots
	// ------------------------------

	// map, data0, data1, load in 2-clock slots
	assign slot = lt.h_cnt[2:1];
	// memory answers one clock after the address
	assign sample = lt.draw && lt.h_cnt[0];
	assign load = sample && (slot == 2'd3);
	assign bg_line = lt.v_cnt + lt.scy_l;
	// signed tile numbers live at 0x1000
	assign tile_a12 = regs.lcdc[ppu_reg_pkg::LCDC_TILE_SEL] ? 1'b0 : ~tile[7];

	// no vram access in the load slot
	assign vram_rd = lt.draw && (slot != 2'd3);

	always_comb begin
		case (slot)
			2'd0: vram_addr = {2'b11, regs.lcdc[ppu_reg_pkg::LCDC_MAP_SEL], bg_line[7:3], col};
			2'd1: vram_addr = {tile_a12, tile, bg_line[2:0], 1'b0};
			default: vram_addr = {tile_a12, tile, bg_line[2:0], 1'b1};
		endcase
	end

	// fetched bytes
	always_ff @(posedge clk) begin
		if (sample && (slot == 2'd0))
			tile <= vram_data;
		if (sample && (slot == 2'd1))
			data0 <= vram_data;
		if (sample && (slot == 2'd2))
			data1 <= vram_data;
	end

	// pixel shifters reload at the end of each group
	always_ff @(posedge clk) begin
		if (load) begin
			shift0 <= data0;
			shift1 <= data1;
		end else begin
			shift0 <= {shift0[6:0], 1'b0};
			shift1 <= {shift1[6:0], 1'b0};
		end
	end

	// ------------------------------
	// pixel control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			skip   <= 3'd0;
			pcnt   <= 8'd0;
			col    <= 5'd0;
		end else if (lt.h_cnt == H_INIT) begin
			// scroll values are latched by now
			active <= 1'b0;
			skip   <= lt.scx_l[2:0];
			pcnt   <= 8'd0;
			col    <= lt.scx_l[7:3];
		end else begin
			if (load) begin
				active <= 1'b1;
				// next map column wraps at 32
				col <= col + 5'd1;
			end else if (lt.line_end) begin
				active <= 1'b0;
			end
			if (active) begin
				// drop the fine scroll pixels first
				if (skip != 3'd0)
					skip <= skip - 3'd1;
				else if (pcnt != PIX_LAST)
					pcnt <= pcnt + 8'd1;
			end
		end
	end

	assign lcd_clkena = active && (skip == 3'd0) && (pcnt != PIX_LAST);

	// colour index msb from the high plane
	assign cidx = {shift1[7], shift0[7]};
	// white when the background is off
	assign lcd_data = regs.lcdc[ppu_reg_pkg::LCDC_BG_ENA] ? regs.bgp[{cidx, 1'b0} +: 2] : 2'b00;

	a_pcnt: assert property (@(posedge clk) disable iff (reset) pcnt <= PIX_LAST);

endmodule

/* ppu_oam_dma.sv */
// OAM DMA engine that copies one source page into the sprite attribute memory
`timescale 1ns/1ps

module ppu_oam_dma #(
	parameter int OAM_BYTES = ppu_reg_pkg::OAM_BYTES
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dma_start,
	input  ppu_reg_pkg::ppu_regs_t regs,
	output logic                   dma_rd,
	output logic [15:0]            dma_addr,
	input  logic [7:0]             dma_data,
	oam_port_if.requester          port
);

	// four clocks per byte
	localparam logic [9:0] CNT_LAST = 10'(4 * OAM_BYTES - 1);

	logic       active;
	logic [9:0] cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt    <= 10'd0;
		end else if (dma_start) begin
			// a new write restarts from byte 0
			active <= 1'b1;
			cnt    <= 10'd0;
		end else if (active) begin
			if (cnt == CNT_LAST)
				active <= 1'b0;
			else
				cnt <= cnt + 10'd1;
		end
	end

	// source page from the DMA register
	assign dma_rd   = active;
	assign dma_addr = {regs.dma, cnt[9:2]};

	// source byte is stable from the second clock of the group
	assign port.req   = active;
	assign port.we    = active && (cnt[1:0] == 2'd2);
	assign port.addr  = cnt[9:2];
	assign port.wdata = dma_data;

	a_cnt: assert property (@(posedge clk) disable iff (reset) cnt <= CNT_LAST);

endmodule

/* ppu_oam_arbiter.sv */
// OAM memory shared by the CPU and DMA ports with the DMA port served first
`timescale 1ns/1ps

module ppu_oam_arbiter #(
	parameter int OAM_BYTES = ppu_reg_pkg::OAM_BYTES
) (
	input  logic       clk,
	oam_port_if.memory cpu_port,
	oam_port_if.memory dma_port
);

	localparam logic [7:0] OAM_END = 8'(OAM_BYTES);

	logic [7:0] oam [OAM_BYTES];
	logic       cpu_hit;
	logic       dma_hit;
	logic       wr_en;
	logic [7:0] wr_addr;
	logic [7:0] wr_data;

	// addresses past the table are not backed
	assign cpu_hit = (cpu_port.addr < OAM_END);
	assign dma_hit = (dma_port.addr < OAM_END);

	// ------------------------------
	// write grant
	// ------------------------------
	always_comb begin
		if (dma_port.req) begin
			// cpu is locked out for the whole transfer
			wr_en   = dma_port.we && dma_hit;
			wr_addr = dma_port.addr;
			wr_data = dma_port.wdata;
		end else begin
			wr_en   = cpu_port.req && cpu_port.we && cpu_hit;
			wr_addr = cpu_port.addr;
			wr_data = cpu_port.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			oam[wr_addr] <= wr_data;
	end

	// reads
	assign dma_port.rdata = dma_hit ? oam[dma_port.addr] : 8'hFF;
	// cpu sees open bus while dma runs
	assign cpu_port.rdata = (!dma_port.req && cpu_hit) ? oam[cpu_port.addr] : 8'hFF;

endmodule

/* ppu_top.sv */
// PPU top level joining registers, line timer, background fetcher and OAM DMA
`timescale 1ns/1ps

module ppu_top #(
	parameter int FRAME_LINES   = ppu_timing_pkg::FRAME_LINES,
	parameter int VISIBLE_LINES = ppu_timing_pkg::VISIBLE_LINES,
	parameter int OAM_BYTES     = ppu_reg_pkg::OAM_BYTES
) (
	input  logic        clk,
	input  logic        reset,
	// cpu side
	input  logic        cpu_sel_oam,
	input  logic        cpu_sel_reg,
	input  logic [7:0]  cpu_addr,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_di,
	output logic [7:0]  cpu_do,
	// lcd side
	output logic        lcd_on,
	output logic        lcd_clkena,
	output logic [1:0]  lcd_data,
	output logic        irq,
	output logic [1:0]  mode,
	// vram
	output logic        vram_rd,
	output logic [12:0] vram_addr,
	input  logic [7:0]  vram_data,
	// dma source
	output logic        dma_rd,
	output logic [15:0] dma_addr,
	input  logic [7:0]  dma_data
);

	ppu_reg_pkg::ppu_regs_t    regs;
	ppu_timing_pkg::ppu_mode_e mode_e;
	logic                      dma_start;

	oam_port_if    cpu_oam ();
	oam_port_if    dma_oam ();
	line_timing_if lt ();

	assign lcd_on = regs.lcdc[ppu_reg_pkg::LCDC_ON];
	assign mode   = mode_e;

	// cpu oam access goes straight to the arbiter
	assign cpu_oam.req   = cpu_sel_oam;
	assign cpu_oam.we    = cpu_wr;
	assign cpu_oam.addr  = cpu_addr;
	assign cpu_oam.wdata = cpu_di;

	ppu_regs u_regs (
		.clk(clk), .reset(reset), .cpu_sel_reg(cpu_sel_reg), .cpu_sel_oam(cpu_sel_oam),
		.cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_di(cpu_di), .oam_rdata(cpu_oam.rdata),
		.ly(lt.v_cnt), .mode(mode_e), .cpu_do(cpu_do), .regs(regs), .dma_start(dma_start)
	);

	ppu_line_timer #(.FRAME_LINES(FRAME_LINES), .VISIBLE_LINES(VISIBLE_LINES)) u_timer (
		.clk(clk), .reset(reset), .regs(regs), .lt(lt), .mode(mode_e), .irq(irq)
	);

	ppu_bg_fetcher u_fetcher (
		.clk(clk), .reset(reset), .regs(regs), .lt(lt), .vram_rd(vram_rd),
		.vram_addr(vram_addr), .vram_data(vram_data), .lcd_clkena(lcd_clkena),
		.lcd_data(lcd_data)
	);

	ppu_oam_dma #(.OAM_BYTES(OAM_BYTES)) u_dma (
		.clk(clk), .reset(reset), .dma_start(dma_start), .regs(regs), .dma_rd(dma_rd),
		.dma_addr(dma_addr), .dma_data(dma_data), .port(dma_oam)
	);

	ppu_oam_arbiter #(.OAM_BYTES(OAM_BYTES)) u_oam (
		.clk(clk), .cpu_port(cpu_oam), .dma_port(dma_oam)
	);

endmodule

/* tb_ppu.sv */
// PPU testbench driving the register bus with VRAM and DMA source models and a stimulus table
`timescale 1ns/1ps

module tb_ppu;

	localparam logic [31:0] SEED = 32'h9803;
	localparam int FRAME_CLKS = 456 * 154;
	localparam logic [1:0] M_HBL = ppu_timing_pkg::HBLANK;
	localparam logic [1:0] M_VBL = ppu_timing_pkg::VBLANK;
	localparam logic [1:0] M_OAM = ppu_timing_pkg::OAM;
	localparam logic [1:0] M_DRW = ppu_timing_pkg::DRAW;

	// one background setup with the line where its irq is due
	typedef struct packed {
		logic [7:0] lcdc;
		logic [7:0] scx;
		logic [7:0] scy;
		logic [7:0] bgp;
		logic [7:0] lyc;
		logic [7:0] stat;
		logic [7:0] irq_ly;
	} row_t;

	localparam int ROWS = 4;
	localparam row_t TABLE [ROWS] = '{
		'{8'h91, 8'h00, 8'h00, 8'hE4, 8'h22, 8'h40, 8'h22},
		'{8'h89, 8'h03, 8'h11, 8'h1B, 8'h00, 8'h10, 8'h90},
		'{8'h99, 8'h7D, 8'hC8, 8'hD2, 8'h90, 8'h40, 8'h90},
		'{8'h80, 8'hF5, 8'h37, 8'h93, 8'h05, 8'h10, 8'h90}
	};

	logic        clk;
	logic        reset;
	logic        cpu_sel_oam;
	logic        cpu_sel_reg;
	logic [7:0]  cpu_addr;
	logic        cpu_wr;
	logic [7:0]  cpu_di;
	logic [7:0]  cpu_do;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	logic        irq;
	logic [1:0]  mode;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data;
	logic        dma_rd;
	logic [15:0] dma_addr;
	logic [7:0]  dma_data;

	ppu_top UUT (
		.clk(clk), .reset(reset), .cpu_sel_oam(cpu_sel_oam), .cpu_sel_reg(cpu_sel_reg),
		.cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_di(cpu_di), .cpu_do(cpu_do),
		.lcd_on(lcd_on), .lcd_clkena(lcd_clkena), .lcd_data(lcd_data), .irq(irq),
		.mode(mode), .vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
		.dma_rd(dma_rd), .dma_addr(dma_addr), .dma_data(dma_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// memory models
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// every address bit reaches the byte
	function automatic logic [7:0] vram_byte(input logic [12:0] a);
		logic [31:0] x;
		x = xorshift(SEED ^ {19'd0, a});
		x = xorshift(x ^ {a, 19'd0});
		return x[7:0];
	endfunction

	function automatic logic [7:0] src_byte(input logic [15:0] a);
		logic [31:0] x;
		x = xorshift(SEED ^ {a, 16'h0000});
		x = xorshift(x ^ {16'h0000, a});
		return x[15:8];
	endfunction

	// both memories answer one clock after the address
	// vram only answers while the read strobe is up
	always @(posedge clk) begin
		vram_data <= vram_rd ? vram_byte(vram_addr) : 8'h00;
		dma_data  <= src_byte(dma_addr);
	end

	// shade of pixel k on line v, straight from the tile map rules
	function automatic logic [1:0] expect_shade(input row_t r, input logic [7:0] v,
		input int k);
		logic [7:0]  x;
		logic [7:0]  y;
		logic [12:0] map;
		logic [7:0]  tile;
		logic        a12;
		logic [11:0] base;
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [2:0]  bi;
		logic [1:0]  c;
		x = r.scx + 8'(k);
		y = v + r.scy;
		map = 13'h1800 + (r.lcdc[3] ? 13'h0400 : 13'h0000) + {3'd0, y[7:3], 5'd0} +
			{8'd0, x[7:3]};
		tile = vram_byte(map);
		a12 = r.lcdc[4] ? 1'b0 : ~tile[7];
		base = {a12, tile, y[2:0]};
		lo = vram_byte({base, 1'b0});
		hi = vram_byte({base, 1'b1});
		// leftmost pixel is the msb
		bi = ~x[2:0];
		c = {hi[bi], lo[bi]};
		if (!r.lcdc[0])
			return 2'b00;
		return r.bgp[{c, 1'b0} +: 2];
	endfunction

	// ------------------------------
	// checks and bus helpers
	// ------------------------------
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic give_up(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
		@(posedge clk);
		cpu_sel_oam <= 1'b0;
		cpu_sel_reg <= 1'b1;
		cpu_wr      <= 1'b1;
		cpu_addr    <= a;
		cpu_di      <= d;
		@(posedge clk);
		cpu_wr      <= 1'b0;
		cpu_sel_reg <= 1'b0;
	endtask

	// leaves the select on so cpu_do keeps following the register
	task automatic read_reg(input logic [7:0] a, output logic [7:0] d);
		@(posedge clk);
		cpu_sel_oam <= 1'b0;
		cpu_sel_reg <= 1'b1;
		cpu_wr      <= 1'b0;
		cpu_addr    <= a;
		@(negedge clk);
		d = cpu_do;
	endtask

	task automatic read_oam(input logic [7:0] a, output logic [7:0] d);
		@(posedge clk);
		cpu_sel_reg <= 1'b0;
		cpu_sel_oam <= 1'b1;
		cpu_wr      <= 1'b0;
		cpu_addr    <= a;
		@(negedge clk);
		d = cpu_do;
	endtask

	// start of line v, seen as LY with mode 2
	task automatic wait_line(input logic [7:0] v);
		logic [7:0] d;
		int n;
		bit found;
		found = 1'b0;
		read_reg(ppu_reg_pkg::REG_LY, d);
		for (n = 0; n < 2 * FRAME_CLKS && !found; n++) begin
			@(negedge clk);
			if (cpu_do == v && mode == M_OAM)
				found = 1'b1;
		end
		if (!found)
			give_up("timeout waiting for the start of a scan line");
	endtask

	// ------------------------------
	// test steps
	// ------------------------------
	task automatic check_registers();
		logic [7:0] d;
		read_reg(ppu_reg_pkg::REG_BGP, d);
		check_val("bgp_reset", 32'(d), 32'h0000_00FC);
		bus_write(ppu_reg_pkg::REG_LCDC, 8'h15);
		// low bits are status only, the written ones must not show
		bus_write(ppu_reg_pkg::REG_STAT, 8'h6B);
		bus_write(ppu_reg_pkg::REG_SCY, 8'h5A);
		bus_write(ppu_reg_pkg::REG_SCX, 8'hA5);
		bus_write(ppu_reg_pkg::REG_LYC, 8'h00);
		bus_write(ppu_reg_pkg::REG_BGP, 8'h3C);
		bus_write(ppu_reg_pkg::REG_OBP0, 8'h12);
		bus_write(ppu_reg_pkg::REG_OBP1, 8'h34);
		bus_write(ppu_reg_pkg::REG_WY, 8'h56);
		bus_write(ppu_reg_pkg::REG_WX, 8'h78);
		read_reg(ppu_reg_pkg::REG_LCDC, d);
		check_val("lcdc", 32'(d), 32'h15);
		read_reg(ppu_reg_pkg::REG_SCY, d);
		check_val("scy", 32'(d), 32'h5A);
		read_reg(ppu_reg_pkg::REG_SCX, d);
		check_val("scx", 32'(d), 32'hA5);
		read_reg(ppu_reg_pkg::REG_BGP, d);
		check_val("bgp", 32'(d), 32'h3C);
		read_reg(ppu_reg_pkg::REG_OBP0, d);
		check_val("obp0", 32'(d), 32'h12);
		read_reg(ppu_reg_pkg::REG_OBP1, d);
		check_val("obp1", 32'(d), 32'h34);
		read_reg(ppu_reg_pkg::REG_WY, d);
		check_val("wy", 32'(d), 32'h56);
		read_reg(ppu_reg_pkg::REG_WX, d);
		check_val("wx", 32'(d), 32'h78);
		// lcd off, so LY is 0 and matches LYC 0
		read_reg(ppu_reg_pkg::REG_STAT, d);
		check_val("stat", 32'(d), 32'h0000_00EC);
		bus_write(ppu_reg_pkg::REG_LYC, 8'h07);
		read_reg(ppu_reg_pkg::REG_LYC, d);
		check_val("lyc", 32'(d), 32'h07);
		read_reg(ppu_reg_pkg::REG_STAT, d);
		check_val("stat_nomatch", 32'(d), 32'h0000_00E8);
		read_reg(ppu_reg_pkg::REG_LY, d);
		check_val("ly_off", 32'(d), 32'h0);
		check_val("mode_off", 32'(mode), 32'h0);
		read_reg(8'h4C, d);
		check_val("unmapped_4c", 32'(d), 32'h0000_00FF);
		read_reg(8'h3F, d);
		check_val("unmapped_3f", 32'(d), 32'h0000_00FF);
	endtask

	task automatic capture_line(input row_t r, input logic [7:0] v);
		int k;
		int n;
		bit done;
		k = 0;
		done = 1'b0;
		wait_line(v);
		for (n = 0; n < 600 && !done; n++) begin
			@(negedge clk);
			if (cpu_do != v) begin
				done = 1'b1;
			end else if (lcd_clkena) begin
				if (k < 160)
					check_val("lcd_data", 32'(lcd_data), 32'(expect_shade(r, v, k)));
				k = k + 1;
			end
		end
		if (!done)
			give_up("timeout waiting for the end of a scan line");
		check_val("pixel_count", 32'(k), 32'd160);
	endtask

	// one frame of cycles holds exactly one enabled event
	task automatic count_irq(input row_t r);
		logic [7:0] d;
		int n;
		int hits;
		hits = 0;
		read_reg(ppu_reg_pkg::REG_LY, d);
		for (n = 0; n < FRAME_CLKS; n++) begin
			@(negedge clk);
			if (irq) begin
				hits = hits + 1;
				check_val("ly_at_irq", 32'(cpu_do), 32'(r.irq_ly));
			end
		end
		check_val("irq_count", 32'(hits), 32'd1);
	endtask

	task automatic check_frame();
		logic [7:0] d;
		logic [7:0] ly;
		logic [7:0] prev_ly;
		logic [1:0] m;
		logic [1:0] prev_m;
		int n;
		int steps;
		steps = 0;
		bus_write(ppu_reg_pkg::REG_LCDC, 8'h00);
		bus_write(ppu_reg_pkg::REG_LCDC, 8'h91);
		read_reg(ppu_reg_pkg::REG_LY, d);
		prev_ly = cpu_do;
		prev_m = mode;
		for (n = 0; n < FRAME_CLKS + 50; n++) begin
			@(negedge clk);
			ly = cpu_do;
			m = mode;
			check_val("mode_is_vblank", 32'(m == M_VBL), 32'(ly >= 8'd144));
			if (ly != prev_ly) begin
				steps = steps + 1;
				check_val("ly", 32'(ly), 32'((prev_ly == 8'd153) ? 8'd0 : prev_ly + 8'd1));
				if (ly < 8'd144)
					check_val("mode_line_start", 32'(m), 32'(M_OAM));
			end else if (ly < 8'd144 && m != prev_m) begin
				// oam search, then draw, then hblank
				check_val("mode_step", 32'(m), 32'((prev_m == M_OAM) ? M_DRW : M_HBL));
				check_val("mode_from", 32'(prev_m == M_HBL), 32'd0);
			end
			prev_ly = ly;
			prev_m = m;
		end
		check_val("line_steps", 32'(steps), 32'd154);
	endtask

	task automatic check_dma();
		logic [7:0] d;
		int n;
		bit done;
		done = 1'b0;
		bus_write(ppu_reg_pkg::REG_DMA, 8'hC1);
		read_oam(8'd0, d);
		check_val("dma_rd", 32'(dma_rd), 32'd1);
		check_val("oam_busy_0", 32'(d), 32'h0000_00FF);
		read_oam(8'd80, d);
		check_val("oam_busy_80", 32'(d), 32'h0000_00FF);
		read_oam(8'd159, d);
		check_val("oam_busy_159", 32'(d), 32'h0000_00FF);
		for (n = 0; n < 700 && !done; n++) begin
			@(negedge clk);
			if (!dma_rd)
				done = 1'b1;
		end
		if (!done)
			give_up("timeout waiting for the OAM DMA to finish");
		for (n = 0; n < 160; n++) begin
			read_oam(8'(n), d);
			check_val("oam", 32'(d), 32'(src_byte({8'hC1, 8'(n)})));
		end
		read_reg(ppu_reg_pkg::REG_DMA, d);
		check_val("dma", 32'(d), 32'hC1);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		reset = 1'b1;
		cpu_sel_oam = 1'b0;
		cpu_sel_reg = 1'b0;
		cpu_addr = 8'h00;
		cpu_wr = 1'b0;
		cpu_di = 8'h00;
		vram_data = 8'h00;
		dma_data = 8'h00;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_val("lcd_on", 32'(lcd_on), 32'd0);
		check_val("irq", 32'(irq), 32'd0);
		check_val("lcd_clkena", 32'(lcd_clkena), 32'd0);
		check_val("vram_rd", 32'(vram_rd), 32'd0);
		check_val("dma_rd", 32'(dma_rd), 32'd0);
		check_val("mode", 32'(mode), 32'd0);

		check_registers();

		for (int i = 0; i < ROWS; i++) begin
			bus_write(ppu_reg_pkg::REG_LCDC, 8'h00);
			bus_write(ppu_reg_pkg::REG_SCX, TABLE[i].scx);
			bus_write(ppu_reg_pkg::REG_SCY, TABLE[i].scy);
			bus_write(ppu_reg_pkg::REG_BGP, TABLE[i].bgp);
			bus_write(ppu_reg_pkg::REG_LYC, TABLE[i].lyc);
			bus_write(ppu_reg_pkg::REG_STAT, TABLE[i].stat);
			bus_write(ppu_reg_pkg::REG_LCDC, TABLE[i].lcdc);
			@(negedge clk);
			check_val("lcd_on", 32'(lcd_on), 32'(TABLE[i].lcdc[ppu_reg_pkg::LCDC_ON]));
			capture_line(TABLE[i], 8'd0);
			capture_line(TABLE[i], 8'd77);
			capture_line(TABLE[i], 8'd143);
			count_irq(TABLE[i]);
		end

		check_frame();
		check_dma();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* tb.f */
ppu_timing_pkg.sv
ppu_reg_pkg.sv
ppu_ifs.sv
ppu_regs.sv
ppu_line_timer.sv
ppu_bg_fetcher.sv
ppu_oam_dma.sv
ppu_oam_arbiter.sv
ppu_top.sv
tb_ppu.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_ppu -f tb.f -o sim_ppu
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_ppu > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"

if grep -F -q "*** FAILED ***" "$LOG"; then
	exit 1
fi
if [ $RUN_STATUS -ne 0 ]; then
	echo "simulation exited with status $RUN_STATUS"
	exit 1
fi
exit 0
